// ==== Makefile ====
SOURCES := $(shell grep -v '^+' files.f) include/cpu_defs.svh

.PHONY: run clean

run: obj_dir/VcpuCore_tb
	./obj_dir/VcpuCore_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

obj_dir/VcpuCore_tb: $(SOURCES) files.f
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpuCore_tb

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+include
verilog/architecture.sv
verilog/controllerPkg.sv
verilog/stallLogic.sv
verilog/conditionCheckLogic.sv
verilog/controllerState.sv
verilog/controlOutputLogic.sv
verilog/controller.sv
verilog/datapath.sv
verilog/cpuCore.sv
tb/cpuCore_chk.sv
tb/cpuCore_tb.sv

// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// one machine word, registers and bus data
`define DATA_WIDTH 16

// program counter and memory address
`define ADDR_WIDTH 8

// selects one of the four registers
`define REG_INDEX_WIDTH 2

`endif

// ==== tb/cpuCore_chk.sv ====
`timescale 1ns/1ns

`include "cpu_defs.svh"

module cpuCore_chk(
    input   logic                       clk,
    input   logic                       rstN,
    input   logic                       memReq,
    input   logic                       memAck,
    input   logic                       memWe,
    input   logic   [`ADDR_WIDTH-1:0]   memAddr,
    input   logic   [`DATA_WIDTH-1:0]   memWdata
    );

    ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(memAck) |-> memReq) else $error("memAck rose without memReq");

    reqDropAfterAck: assert property (@(posedge clk) disable iff (!rstN)
        $fell(memReq) |-> $past(memAck)) else $error("memReq dropped before memAck");

    // the core decides to raise memReq on the ack value of the edge before
    reqRiseAckLow: assert property (@(posedge clk) disable iff (!rstN)
        $rose(memReq) |-> !$past(memAck)) else $error("memReq rose while memAck high");

    ackDropAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $fell(memAck) |-> !memReq) else $error("memAck dropped while memReq high");

    // address and direction hold for the whole request
    stableAddr: assert property (@(posedge clk) disable iff (!rstN)
        memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWe))
        else $error("memAddr or memWe changed during a request");

    stableWdata: assert property (@(posedge clk) disable iff (!rstN)
        memReq && memWe && $past(memReq) |-> $stable(memWdata))
        else $error("memWdata changed during a write");

    reqLowInReset: assert property (@(posedge clk)
        !rstN |=> !memReq) else $error("memReq high during reset");

endmodule

// ==== tb/cpuCore_tb.sv ====
`timescale 1ns/1ns

`include "cpu_defs.svh"

module cpuCore_tb;

    localparam int PROGRAM_LENGTH = 40;
    localparam int RUNS = 3;
    localparam int CYCLE_LIMIT = RUNS * PROGRAM_LENGTH * 24;

    logic                       clk;
    logic                       rstN;
    logic                       memAck;
    logic   [`DATA_WIDTH-1:0]   memRdata;
    logic                       memReq;
    logic                       memWe;
    logic   [`ADDR_WIDTH-1:0]   memAddr;
    logic   [`DATA_WIDTH-1:0]   memWdata;
    logic                       halted;

    logic   [15:0]              lfsrState;
    logic   [`DATA_WIDTH-1:0]   mem [256];
    logic   [`DATA_WIDTH-1:0]   modelMem [256];
    logic                       expWe [$];
    logic   [`ADDR_WIDTH-1:0]   expAddr [$];
    logic   [`DATA_WIDTH-1:0]   expData [$];
    int                         errorCount;
    int                         runErrors;
    int                         failedRuns;
    int                         transactionCount;
    int                         cycleCount;

    cpuCore i_cpuCore(
        .clk, .rstN, .memAck, .memRdata,
        .memReq, .memWe, .memAddr, .memWdata, .halted
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic int unsigned randBits(input int n);
        int unsigned value;
        logic feedback;
        value = 0;
        for (int i = 0; i < n; i++) begin
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value = (value << 1) | int'(feedback);
        end
        return value;
    endfunction

    task automatic pushTransaction(input logic we, input logic [7:0] addr,
                                   input logic [15:0] data);
        expWe.push_back(we);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic generateProgram();
        int unsigned op;
        logic [15:0] word;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hA5, 8'(i)};
        end
        for (int i = 8'h80; i < 256; i++) begin
            mem[i] = 16'(randBits(16));                 // data area
        end
        for (int pc = 0; pc < PROGRAM_LENGTH - 1; pc++) begin
            op = randBits(4) % 9;
            word = {4'(op), 2'(randBits(2)), 2'(randBits(2)), 8'(randBits(8))};
            if (4'(op) == architecture::LD || 4'(op) == architecture::ST) begin
                word[7] = 1'b1;                         // keep loads and stores above 0x80
            end
            if (4'(op) == architecture::BR) begin
                word[7:0] = 8'(pc + 1 + int'(randBits(6) % (PROGRAM_LENGTH - 1 - pc)));
            end
            mem[pc] = word;
        end
        // last word is HALT or one of the undefined opcodes
        mem[PROGRAM_LENGTH-1] = {4'(9 + randBits(3) % 7), 12'h000};
    endtask

    // ISA model, builds the expected bus transactions
    task automatic runModel();
        logic [15:0] regs [4];
        logic [3:0] flags;
        logic [7:0] pc;
        logic [15:0] word;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic [3:0] op;
        logic [7:0] imm;
        int wide;
        int signedWide;
        logic take;
        logic running;
        expWe.delete();
        expAddr.delete();
        expData.delete();
        for (int i = 0; i < 4; i++) begin
            regs[i] = 16'h0;
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = mem[i];
        end
        flags = 4'h0;
        pc = 8'h0;
        running = 1'b1;
        while (running) begin
            pushTransaction(1'b0, pc, 16'h0);
            word = modelMem[pc];
            pc = pc + 8'd1;
            op = word[15:12];
            imm = word[7:0];
            a = regs[word[11:10]];
            b = regs[word[9:8]];
            case (op)
                4'h0, 4'h1: begin
                    if (op == 4'h0) begin
                        wide = int'(a) + int'(b);
                        signedWide = int'($signed(a)) + int'($signed(b));
                        flags[architecture::FLAG_C] = (wide > 32'hFFFF);
                    end else begin
                        wide = int'(a) - int'(b);
                        signedWide = int'($signed(a)) - int'($signed(b));
                        flags[architecture::FLAG_C] = (a >= b);     // no borrow
                    end
                    r = wide[15:0];
                    flags[architecture::FLAG_V] = (signedWide > 32767) || (signedWide < -32768);
                    flags[architecture::FLAG_N] = r[15];
                    flags[architecture::FLAG_Z] = (r == 16'h0);
                    regs[word[11:10]] = r;
                end
                4'h2, 4'h3, 4'h4: begin
                    if (op == 4'h2) begin
                        r = a & b;
                    end else if (op == 4'h3) begin
                        r = a | b;
                    end else begin
                        r = a ^ b;
                    end
                    flags = {r[15], r == 16'h0, 2'b00};
                    regs[word[11:10]] = r;
                end
                4'h5: regs[word[11:10]] = {8'h00, imm};
                4'h6: begin
                    pushTransaction(1'b0, imm, 16'h0);
                    regs[word[11:10]] = modelMem[imm];
                end
                4'h7: begin
                    pushTransaction(1'b1, imm, a);
                    modelMem[imm] = a;
                end
                4'h8: begin
                    case (word[11:9])
                        3'd0:    take = 1'b1;
                        3'd1:    take = flags[architecture::FLAG_Z];
                        3'd2:    take = !flags[architecture::FLAG_Z];
                        3'd3:    take = flags[architecture::FLAG_C];
                        3'd4:    take = !flags[architecture::FLAG_C];
                        3'd5:    take = flags[architecture::FLAG_N];
                        3'd6:    take = !flags[architecture::FLAG_N];
                        default: take = flags[architecture::FLAG_V];
                    endcase
                    if (take) pc = imm;
                end
                default: running = 1'b0;
            endcase
        end
    endtask

    task automatic checkTransaction();
        transactionCount++;
        if (expAddr.size() == 0) begin
            $display("ERR %0t: unexpected bus request, we %b address %h",
                $time, memWe, memAddr);
            runErrors++;
        end else begin
            if (memWe !== expWe[0] || memAddr !== expAddr[0]
                || (memWe === 1'b1 && memWdata !== expData[0])) begin
                $display("ERR %0t: bus we %b address %h data %h, expected we %b address %h data %h",
                    $time, memWe, memAddr, memWdata, expWe[0], expAddr[0], expData[0]);
                runErrors++;
            end
            void'(expWe.pop_front());
            void'(expAddr.pop_front());
            void'(expData.pop_front());
        end
    endtask

    // memory responder, random delay on both edges of ack
    initial begin : responder
        int unsigned delay;
        forever begin
            @(posedge clk);
            #2;
            if (rstN && memReq && !memAck) begin
                delay = randBits(2);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                checkTransaction();
                if (memWe) mem[memAddr] = memWdata;
                memRdata = mem[memAddr];
                memAck = 1'b1;
                do begin
                    @(posedge clk);
                    #2;
                end while (memReq);
                delay = randBits(2);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                memAck = 1'b0;
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the core did not finish all programs within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        memAck = 1'b0;
        memRdata = '0;
        lfsrState = 16'd76;
        errorCount = 0;
        failedRuns = 0;
        for (int run = 0; run < RUNS; run++) begin
            rstN = 1'b0;
            runErrors = 0;
            transactionCount = 0;
            generateProgram();
            runModel();
            repeat (4) @(posedge clk);
            #2;
            rstN = 1'b1;
            if (memReq !== 1'b0 || halted !== 1'b0) begin
                $display("ERR %0t: memReq %b halted %b after reset", $time, memReq, halted);
                runErrors++;
            end
            while (halted !== 1'b1) begin
                @(posedge clk);
                #2;
            end
            if (expAddr.size() != 0) begin
                $display("ERR %0t: halted with %0d expected transactions left",
                    $time, expAddr.size());
                runErrors++;
            end
            repeat (20) begin
                @(posedge clk);
                #2;
                if (memReq !== 1'b0 || halted !== 1'b1) begin
                    $display("ERR %0t: activity after halt, memReq %b halted %b",
                        $time, memReq, halted);
                    runErrors++;
                end
            end
            $display("run %0d: %0d bus transactions, %0d errors", run, transactionCount, runErrors);
            errorCount += runErrors;
            if (runErrors != 0) failedRuns++;
        end
        $display("%0d runs, %0d failed, %0d errors", RUNS, failedRuns, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

bind cpuCore cpuCore_chk busChecker(
    .clk, .rstN, .memReq, .memAck, .memWe, .memAddr, .memWdata
);

// ==== verilog/architecture.sv ====
package architecture;

    // instruction word: [15:12] opcode, [11:10] rd, [9:8] rs, [7:0] immediate
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        LDI  = 4'h5,
        LD   = 4'h6,
        ST   = 4'h7,
        BR   = 4'h8,
        HALT = 4'hF         // 9 to E decode as halt as well
    } opcodes;

    typedef enum logic [2:0] {
        ALWAYS = 3'd0,
        EQ     = 3'd1,
        NE     = 3'd2,
        CS     = 3'd3,
        CC     = 3'd4,
        MI     = 3'd5,
        PL     = 3'd6,
        VS     = 3'd7
    } conditions;

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

endpackage

// ==== verilog/conditionCheckLogic.sv ====
`timescale 1ns/1ns

module conditionCheckLogic(
    input   architecture::conditions    condition,
    input   logic               [3:0]   flags,
    output  logic                       conditionResult
    );


    always_comb begin
        case (condition)
            architecture::ALWAYS:   conditionResult = 1'b1;
            architecture::EQ:       conditionResult = flags[architecture::FLAG_Z];
            architecture::NE:       conditionResult = !flags[architecture::FLAG_Z];
            architecture::CS:       conditionResult = flags[architecture::FLAG_C];
            architecture::CC:       conditionResult = !flags[architecture::FLAG_C];
            architecture::MI:       conditionResult = flags[architecture::FLAG_N];
            architecture::PL:       conditionResult = !flags[architecture::FLAG_N];
            architecture::VS:       conditionResult = flags[architecture::FLAG_V];
            default:                conditionResult = 1'b0;
        endcase
    end


endmodule

// ==== verilog/controlOutputLogic.sv ====
`timescale 1ns/1ns

module controlOutputLogic(
    input   logic                           clk,
    input   logic                           rstN,
    input   logic                           enable,
    input   architecture::opcodes           instruction,
    input   controllerPkg::states           state,
    input   controllerPkg::states           nextState,
    output  logic                           irLoad,
    output  logic                           pcIncrement,
    output  logic                           pcLoad,
    output  logic                           regWrite,
    output  controllerPkg::resultSelects    resultSelect,
    output  controllerPkg::aluOps           aluOp,
    output  logic                           flagsWrite,
    output  logic                           mdrLoad,
    output  logic                           addressFromImmediate,
    output  logic                           memReq,
    output  logic                           memWe,
    output  logic                           halted
    );


    logic                           aluInstruction;
    controllerPkg::aluOps           aluOpDecoded;
    logic                           executeNext;

    assign executeNext = (nextState == controllerPkg::EXECUTE);

    always_comb begin
        aluInstruction = 1'b1;
        case (instruction)
            architecture::ADD:  aluOpDecoded = controllerPkg::ADD;
            architecture::SUB:  aluOpDecoded = controllerPkg::SUB;
            architecture::AND:  aluOpDecoded = controllerPkg::AND;
            architecture::OR:   aluOpDecoded = controllerPkg::OR;
            architecture::XOR:  aluOpDecoded = controllerPkg::XOR;
            default: begin
                aluOpDecoded = controllerPkg::PASS;
                aluInstruction = 1'b0;
            end
        endcase
    end


    always_ff @(posedge clk) begin
        if (!rstN) begin
            irLoad <= 1'b0;
            pcIncrement <= 1'b0;
            pcLoad <= 1'b0;
            regWrite <= 1'b0;
            resultSelect <= controllerPkg::ALU;
            aluOp <= controllerPkg::PASS;
            flagsWrite <= 1'b0;
            mdrLoad <= 1'b0;
            addressFromImmediate <= 1'b0;
            memReq <= 1'b0;
            memWe <= 1'b0;
            halted <= 1'b0;
        end else begin
            // ir and mdr track the bus until the ack edge leaves the wait state
            irLoad <= (nextState == controllerPkg::FETCH1);
            mdrLoad <= (nextState == controllerPkg::MEM1) && (instruction == architecture::LD);
            pcIncrement <= enable && (state == controllerPkg::FETCH1);   // single pulse
            pcLoad <= executeNext && (instruction == architecture::BR);  // taken only

            regWrite <= (executeNext && (aluInstruction || instruction == architecture::LDI))
                || (nextState == controllerPkg::WRITEBACK);
            flagsWrite <= executeNext && aluInstruction;
            aluOp <= aluOpDecoded;

            if (nextState == controllerPkg::WRITEBACK) begin
                resultSelect <= controllerPkg::MEMORY;
            end else if (instruction == architecture::LDI) begin
                resultSelect <= controllerPkg::IMMEDIATE;
            end else begin
                resultSelect <= controllerPkg::ALU;
            end

            addressFromImmediate <= nextState inside {controllerPkg::MEM0,
                controllerPkg::MEM1, controllerPkg::MEM2};

            if (nextState == controllerPkg::FETCH1 || nextState == controllerPkg::MEM1) begin
                memReq <= 1'b1;                                         // open
                memWe <= (nextState == controllerPkg::MEM1) && (instruction == architecture::ST);
            end else if (memReq && enable) begin
                memReq <= 1'b0;                                         // ack seen, close
                memWe <= 1'b0;
            end

            halted <= (nextState == controllerPkg::HALTED);
        end
    end


endmodule

// ==== verilog/controller.sv ====
`timescale 1ns/1ns

module controller(
    input   logic                           clk,
    input   logic                           rstN,
    input   architecture::opcodes           opcode,
    input   architecture::conditions        condition,
    input   logic                   [3:0]   flags,
    input   logic                           memAck,
    output  logic                           irLoad,
    output  logic                           pcIncrement,
    output  logic                           pcLoad,
    output  logic                           regWrite,
    output  controllerPkg::resultSelects    resultSelect,
    output  controllerPkg::aluOps           aluOp,
    output  logic                           flagsWrite,
    output  logic                           mdrLoad,
    output  logic                           addressFromImmediate,
    output  logic                           memReq,
    output  logic                           memWe,
    output  logic                           halted
    );


    architecture::opcodes       instruction;
    logic                       enable;
    controllerPkg::states       state;
    controllerPkg::states       nextState;
    logic                       conditionResult;


    assign instruction = opcode;                // no separate decoder needed


    stallLogic
    stallLogic(
        .state,
        .memAck,
        .enable
    );


    controllerState
    controllerState(
        .clk,
        .rstN,
        .enable,
        .instruction,
        .conditionResult,
        .state,
        .nextState
    );


    conditionCheckLogic
    conditionCheckLogic(
        .condition,
        .flags,
        .conditionResult
    );


    controlOutputLogic
    controlOutputLogic(
        .clk,
        .rstN,
        .enable,
        .instruction,
        .state,
        .nextState,
        .irLoad,
        .pcIncrement,
        .pcLoad,
        .regWrite,
        .resultSelect,
        .aluOp,
        .flagsWrite,
        .mdrLoad,
        .addressFromImmediate,
        .memReq,
        .memWe,
        .halted
    );


endmodule

// ==== verilog/controllerPkg.sv ====
package controllerPkg;

    typedef enum logic [3:0] {
        FETCH0,
        FETCH1,
        FETCH2,
        EXECUTE,
        MEM0,
        MEM1,
        MEM2,
        WRITEBACK,
        HALTED
    } states;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS                // rs straight through, idle setting
    } aluOps;

    typedef enum logic [1:0] {
        ALU,
        IMMEDIATE,
        MEMORY
    } resultSelects;

endpackage

// ==== verilog/controllerState.sv ====
`timescale 1ns/1ns

module controllerState(
    input   logic                       clk,
    input   logic                       rstN,
    input   logic                       enable,
    input   architecture::opcodes       instruction,
    input   logic                       conditionResult,
    output  controllerPkg::states       state,
    output  controllerPkg::states       nextState
    );


    always_comb begin
        nextState = state;                                  // hold while stalled
        if (enable) begin
            case (state)
                controllerPkg::FETCH0:  nextState = controllerPkg::FETCH1;
                controllerPkg::FETCH1:  nextState = controllerPkg::FETCH2;

                // a branch that fails its condition has nothing to execute
                controllerPkg::FETCH2: begin
                    if (instruction == architecture::BR && !conditionResult) begin
                        nextState = controllerPkg::FETCH0;
                    end else begin
                        nextState = controllerPkg::EXECUTE;
                    end
                end

                controllerPkg::EXECUTE: begin
                    case (instruction)
                        architecture::ADD,
                        architecture::SUB,
                        architecture::AND,
                        architecture::OR,
                        architecture::XOR,
                        architecture::LDI,
                        architecture::BR:   nextState = controllerPkg::FETCH0;
                        architecture::LD,
                        architecture::ST:   nextState = controllerPkg::MEM0;
                        default:            nextState = controllerPkg::HALTED;
                    endcase
                end

                controllerPkg::MEM0:    nextState = controllerPkg::MEM1;
                controllerPkg::MEM1:    nextState = controllerPkg::MEM2;

                controllerPkg::MEM2: begin
                    if (instruction == architecture::LD) begin
                        nextState = controllerPkg::WRITEBACK;
                    end else begin
                        nextState = controllerPkg::FETCH0;
                    end
                end

                controllerPkg::WRITEBACK:   nextState = controllerPkg::FETCH0;
                default:                    nextState = controllerPkg::HALTED;
            endcase
        end
    end


    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= controllerPkg::FETCH0;
        end else if (enable) begin
            state <= nextState;
        end
    end


endmodule

// ==== verilog/cpuCore.sv ====
`timescale 1ns/1ns

`include "cpu_defs.svh"

module cpuCore(
    input   logic                       clk,
    input   logic                       rstN,
    input   logic                       memAck,
    input   logic   [`DATA_WIDTH-1:0]   memRdata,
    output  logic                       memReq,
    output  logic                       memWe,
    output  logic   [`ADDR_WIDTH-1:0]   memAddr,
    output  logic   [`DATA_WIDTH-1:0]   memWdata,
    output  logic                       halted
    );


    architecture::opcodes           opcode;
    architecture::conditions        condition;
    logic                   [3:0]   flags;
    logic                           irLoad;
    logic                           pcIncrement;
    logic                           pcLoad;
    logic                           regWrite;
    controllerPkg::resultSelects    resultSelect;
    controllerPkg::aluOps           aluOp;
    logic                           flagsWrite;
    logic                           mdrLoad;
    logic                           addressFromImmediate;


    controller
    controller(
        .clk, .rstN, .opcode, .condition, .flags, .memAck,
        .irLoad, .pcIncrement, .pcLoad, .regWrite, .resultSelect, .aluOp,
        .flagsWrite, .mdrLoad, .addressFromImmediate, .memReq, .memWe, .halted
    );


    datapath
    datapath(
        .clk, .rstN, .irLoad, .pcIncrement, .pcLoad, .regWrite, .resultSelect,
        .aluOp, .flagsWrite, .mdrLoad, .addressFromImmediate, .memRdata,
        .opcode, .condition, .flags, .memAddr, .memWdata
    );


endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ns

`include "cpu_defs.svh"

module datapath(
    input   logic                           clk,
    input   logic                           rstN,
    input   logic                           irLoad,
    input   logic                           pcIncrement,
    input   logic                           pcLoad,
    input   logic                           regWrite,
    input   controllerPkg::resultSelects    resultSelect,
    input   controllerPkg::aluOps           aluOp,
    input   logic                           flagsWrite,
    input   logic                           mdrLoad,
    input   logic                           addressFromImmediate,
    input   logic   [`DATA_WIDTH-1:0]       memRdata,
    output  architecture::opcodes           opcode,
    output  architecture::conditions        condition,
    output  logic   [3:0]                   flags,
    output  logic   [`ADDR_WIDTH-1:0]       memAddr,
    output  logic   [`DATA_WIDTH-1:0]       memWdata
    );


    localparam int MSB = `DATA_WIDTH - 1;

    logic   [`DATA_WIDTH-1:0]       ir;
    logic   [`DATA_WIDTH-1:0]       mdr;
    logic   [`ADDR_WIDTH-1:0]       pc;
    logic   [`DATA_WIDTH-1:0]       registers [2**`REG_INDEX_WIDTH];
    logic   [`REG_INDEX_WIDTH-1:0]  rd;
    logic   [`REG_INDEX_WIDTH-1:0]  rs;
    logic   [`ADDR_WIDTH-1:0]       immediate;
    logic   [`DATA_WIDTH-1:0]       a;
    logic   [`DATA_WIDTH-1:0]       b;
    logic   [`DATA_WIDTH:0]         sum;
    logic   [`DATA_WIDTH-1:0]       aluResult;
    logic                           aluCarry;
    logic                           aluOverflow;
    logic   [`DATA_WIDTH-1:0]       result;

    assign opcode = architecture::opcodes'(ir[15:12]);
    assign condition = architecture::conditions'(ir[11:9]);    // overlaps rd and rs
    assign rd = ir[11:10];
    assign rs = ir[9:8];
    assign immediate = ir[`ADDR_WIDTH-1:0];

    assign a = registers[rd];
    assign b = registers[rs];
    assign memAddr = addressFromImmediate ? immediate : pc;
    assign memWdata = a;

    always_comb begin
        sum = '0;
        aluCarry = 1'b0;
        aluOverflow = 1'b0;
        case (aluOp)
            controllerPkg::ADD: begin
                sum = {1'b0, a} + {1'b0, b};
                aluCarry = sum[`DATA_WIDTH];
                aluOverflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            controllerPkg::SUB: begin
                sum = {1'b0, a} - {1'b0, b};
                aluCarry = !sum[`DATA_WIDTH];                   // carry means no borrow
                aluOverflow = (a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]);
            end
            controllerPkg::AND: sum = {1'b0, a & b};
            controllerPkg::OR:  sum = {1'b0, a | b};
            controllerPkg::XOR: sum = {1'b0, a ^ b};
            default:            sum = {1'b0, b};
        endcase
        aluResult = sum[MSB:0];
    end

    always_comb begin
        case (resultSelect)
            controllerPkg::IMMEDIATE:   result = {{(`DATA_WIDTH-`ADDR_WIDTH){1'b0}}, immediate};
            controllerPkg::MEMORY:      result = mdr;
            default:                    result = aluResult;
        endcase
    end

    // ir and mdr keep loading during the wait, last load is the acked word
    always_ff @(posedge clk) begin
        if (irLoad) ir <= memRdata;
        if (mdrLoad) mdr <= memRdata;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            flags <= '0;
            for (int i = 0; i < 2**`REG_INDEX_WIDTH; i++) begin
                registers[i] <= '0;
            end
        end else begin
            if (pcLoad) begin
                pc <= immediate;                                // absolute target
            end else if (pcIncrement) begin
                pc <= pc + 1'b1;
            end
            if (regWrite) registers[rd] <= result;
            if (flagsWrite) begin
                flags[architecture::FLAG_N] <= aluResult[MSB];
                flags[architecture::FLAG_Z] <= (aluResult == '0);
                flags[architecture::FLAG_C] <= aluCarry;
                flags[architecture::FLAG_V] <= aluOverflow;
            end
        end
    end


endmodule

// ==== verilog/stallLogic.sv ====
`timescale 1ns/1ns

module stallLogic(
    input   controllerPkg::states       state,
    input   logic                       memAck,
    output  logic                       enable
    );


    // the bus handshake is only ever waited on here
    always_comb begin
        case (state)
            controllerPkg::FETCH1,
            controllerPkg::MEM1:    enable = memAck;        // wait for ack
            controllerPkg::FETCH2,
            controllerPkg::MEM2:    enable = !memAck;       // wait for ack to drop
            controllerPkg::HALTED:  enable = 1'b0;
            default:                enable = 1'b1;
        endcase
    end


endmodule
